/* hdl/screen_pkg.sv */
`default_nettype none

package screen_pkg;

    typedef logic [9:0] coord_t;
    typedef logic [5:0] color_t;

    typedef struct packed {
        coord_t col;
        coord_t row;
    } pixel_t;

    localparam coord_t BLOCKSIZE = 10'd32;

    // visible playfield columns
    localparam coord_t X_OFFSET_LEFT  = 10'd96;
    localparam coord_t X_OFFSET_RIGHT = 10'd544;

    // circular track that log x positions live on
    localparam coord_t X_WRAP_LO = 10'd64;
    localparam coord_t X_WRAP_HI = 10'd576;
    localparam coord_t TRACK_LEN = 10'd512;

    localparam color_t COLOR_NONE = 6'b000000;
    localparam color_t LOG_BODY   = 6'b100010;
    localparam color_t LOG_GRAIN  = 6'b010001;
    localparam color_t LOG_KNOT   = 6'b010000;
    localparam color_t LOG_CAP    = 6'b110011;

endpackage

`default_nettype wire

/* hdl/river_pkg.sv */
`default_nettype none

package river_pkg;

    import screen_pkg::*;

    localparam int NUM_LANES     = 6;
    localparam int LOGS_PER_LANE = 3;

    typedef struct packed {
        coord_t log2;
        coord_t log1;
        coord_t log0;
    } lane_logs_t;

    typedef lane_logs_t [NUM_LANES-1:0] river_state_t;

    typedef logic [1:0] level_t;

    // {local row[4:0], local column[4:0]}
    typedef logic [9:0] sprite_addr_t;

    localparam coord_t LANE_LENGTH [NUM_LANES] = '{10'd96, 10'd64, 10'd128, 10'd96, 10'd160, 10'd64};
    localparam coord_t LANE_SPEED [NUM_LANES] = '{10'd1, 10'd2, 10'd1, 10'd3, 10'd1, 10'd2};

    // bit k set when lane k moves right
    localparam logic [NUM_LANES-1:0] LANE_DIR_RIGHT = 6'b010101;

    // logs in a lane start about a third of the track apart
    localparam river_state_t LOG_START = '{
        0: '{log0: 10'd96,  log1: 10'd266, log2: 10'd436},
        1: '{log0: 10'd120, log1: 10'd290, log2: 10'd460},
        2: '{log0: 10'd80,  log1: 10'd250, log2: 10'd420},
        3: '{log0: 10'd140, log1: 10'd310, log2: 10'd480},
        4: '{log0: 10'd100, log1: 10'd270, log2: 10'd440},
        5: '{log0: 10'd160, log1: 10'd330, log2: 10'd500}
    };

    localparam coord_t LANE_Y [NUM_LANES] = '{
        1 * BLOCKSIZE, 2 * BLOCKSIZE, 3 * BLOCKSIZE,
        4 * BLOCKSIZE, 5 * BLOCKSIZE, 6 * BLOCKSIZE
    };

endpackage

`default_nettype wire

/* hdl/log_motion.sv */
`timescale 1ns/1ns
`default_nettype none

module log_motion (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    frame_tick,
    input  river_pkg::level_t       level,
    output river_pkg::river_state_t logs
);

    import screen_pkg::*;
    import river_pkg::*;

    coord_t level_scale;
    coord_t lane_step [NUM_LANES];

    // one frame of movement on the circular track
    function automatic coord_t advance(
        input coord_t x,
        input coord_t step,
        input logic   right
    );
        coord_t nx;
        if (right) begin
            nx = x + step;
            if (nx >= X_WRAP_HI) begin
                nx = nx - TRACK_LEN;
            end
        end else begin
            nx = x - step;
            if (nx < X_WRAP_LO) begin
                nx = nx + TRACK_LEN;
            end
        end
        return nx;
    endfunction

    // level 0 runs at base speed, level 3 at four times
    assign level_scale = coord_t'(level) + coord_t'(1);

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            lane_step[k] = LANE_SPEED[k] * level_scale;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            logs <= LOG_START;
        end else if (frame_tick) begin
            for (int k = 0; k < NUM_LANES; k++) begin
                logs[k].log0 <= advance(logs[k].log0, lane_step[k], LANE_DIR_RIGHT[k]);
                logs[k].log1 <= advance(logs[k].log1, lane_step[k], LANE_DIR_RIGHT[k]);
                logs[k].log2 <= advance(logs[k].log2, lane_step[k], LANE_DIR_RIGHT[k]);
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/log_sprite_rom.sv */
`timescale 1ns/1ns
`default_nettype none

module log_sprite_rom (
    input  logic                    clk,
    input  river_pkg::sprite_addr_t addr,
    output screen_pkg::color_t      data
);

    import screen_pkg::*;
    import river_pkg::*;

    color_t mem [2**$bits(sprite_addr_t)];

    // grain lines every 8 rows, a knot every 16 columns between them
    function automatic color_t wood_pixel(input sprite_addr_t a);
        logic [4:0] y;
        logic [4:0] x;
        y = a[9:5];
        x = a[4:0];
        if (y[2:0] == 3'd0) begin
            return LOG_GRAIN;
        end else if (y[2:0] == 3'd4 && x[3:0] == 4'd7) begin
            return LOG_KNOT;
        end
        return LOG_BODY;
    endfunction

    initial begin
        for (int i = 0; i < 2**$bits(sprite_addr_t); i++) begin
            mem[i] = wood_pixel(sprite_addr_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        data <= mem[addr];
    end

endmodule

`default_nettype wire

/* hdl/log_pixel_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module log_pixel_gen (
    input  logic                    clk,
    input  logic                    reset,
    input  screen_pkg::pixel_t      pixel,
    input  river_pkg::river_state_t logs,
    output river_pkg::sprite_addr_t rom_addr,
    input  screen_pkg::color_t      rom_data,
    output screen_pkg::color_t      color
);

    import screen_pkg::*;
    import river_pkg::*;

    logic   in_window;
    logic   hit_c;
    logic   cap_c;
    coord_t local_col;
    coord_t local_row;

    logic   hit_s1;
    logic   cap_s1;
    logic   hit_s2;
    logic   cap_s2;

    assign in_window = (pixel.col >= X_OFFSET_LEFT) && (pixel.col < X_OFFSET_RIGHT);

    // hit test, lanes in order and logs in order, first match wins
    always_comb begin
        coord_t xs [LOGS_PER_LANE];
        coord_t off;
        hit_c     = 1'b0;
        cap_c     = 1'b0;
        local_col = '0;
        local_row = '0;
        off       = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            xs[0] = logs[k].log0;
            xs[1] = logs[k].log1;
            xs[2] = logs[k].log2;
            if (!hit_c && in_window &&
                pixel.row >= LANE_Y[k] && pixel.row < LANE_Y[k] + BLOCKSIZE) begin
                for (int j = 0; j < LOGS_PER_LANE; j++) begin
                    // columns left of x can only be the wrapped tail of the log
                    if (pixel.col >= xs[j]) begin
                        off = pixel.col - xs[j];
                    end else begin
                        off = pixel.col + TRACK_LEN - xs[j];
                    end
                    if (!hit_c && off < LANE_LENGTH[k]) begin
                        hit_c     = 1'b1;
                        cap_c     = (off == '0) || (off == LANE_LENGTH[k] - coord_t'(1));
                        local_col = off;
                        local_row = pixel.row - LANE_Y[k];
                    end
                end
            end
        end
    end

    // stage 1 feeds the sprite rom, stage 2 lines the flags up with its output
    always_ff @(posedge clk) begin
        if (reset) begin
            hit_s1 <= 1'b0;
            cap_s1 <= 1'b0;
            hit_s2 <= 1'b0;
            cap_s2 <= 1'b0;
        end else begin
            hit_s1 <= hit_c;
            cap_s1 <= cap_c;
            hit_s2 <= hit_s1;
            cap_s2 <= cap_s1;
        end
    end

    always_ff @(posedge clk) begin
        rom_addr <= {local_row[4:0], local_col[4:0]};
    end

    always_comb begin
        if (!hit_s2) begin
            color = COLOR_NONE;
        end else if (cap_s2) begin
            color = LOG_CAP;
        end else begin
            color = rom_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/river_top.sv */
`timescale 1ns/1ns
`default_nettype none

module river_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                frame_tick,
    input  river_pkg::level_t   level,
    input  screen_pkg::pixel_t  pixel,
    output screen_pkg::color_t  color
);

    import screen_pkg::*;
    import river_pkg::*;

    river_state_t logs;
    sprite_addr_t rom_addr;
    color_t       rom_data;

    log_motion u_motion (
        .clk        (clk),
        .reset      (reset),
        .frame_tick (frame_tick),
        .level      (level),
        .logs       (logs)
    );

    // two cycles from pixel to color
    log_pixel_gen u_pixel_gen (
        .clk      (clk),
        .reset    (reset),
        .pixel    (pixel),
        .logs     (logs),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .color    (color)
    );

    log_sprite_rom u_sprite_rom (
        .clk  (clk),
        .addr (rom_addr),
        .data (rom_data)
    );

endmodule

`default_nettype wire

/* bench/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk
);

    // 40 ns period
    localparam int HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* bench/river_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module river_tb;

    import screen_pkg::*;
    import river_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int FRAME_GAP    = 4;

    logic   clk;
    logic   reset;
    logic   frame_tick;
    level_t level;
    pixel_t pixel;
    color_t color;

    // probes in flight and the cycle each one is due
    pixel_t probe_q [$];
    color_t exp_q [$];
    int     due_q [$];

    int   cycle_count;
    int   error_count;
    int   cmd_lines;
    int   frame_pulses;
    int   reset_cmds;
    int   timeout_cycles;
    logic timeout_ready;

    tb_clock u_clock (
        .clk (clk)
    );

    river_top UUT (
        .clk        (clk),
        .reset      (reset),
        .frame_tick (frame_tick),
        .level      (level),
        .pixel      (pixel),
        .color      (color)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_color(input color_t got, input color_t expected, input pixel_t px);
        if (got !== expected) begin
            error_count++;
            abort_run($sformatf("[ERROR] %0t ns: pixel col %0d row %0d gave color %h, expected %h",
                                $time, px.col, px.row, got, expected));
        end
    endtask

    // inputs change and outputs are sampled 5 ns after the edge
    task automatic tick_cycle;
        pixel_t px;
        color_t ex;
        @(posedge clk);
        #5;
        cycle_count++;
        while (due_q.size() > 0 && due_q[0] <= cycle_count) begin
            px = probe_q.pop_front();
            ex = exp_q.pop_front();
            due_q.delete(0);
            check_color(color, ex, px);
        end
    endtask

    task automatic drain_pipeline;
        while (due_q.size() > 0) begin
            tick_cycle();
            pixel = '0;
        end
    endtask

    // pixel held on a start log while the pipeline flags are cleared
    task automatic do_reset;
        reset       = 1'b1;
        pixel.col   = 10'd96;
        pixel.row   = 10'd32;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            tick_cycle();
            check_color(color, COLOR_NONE, pixel);
        end
        reset = 1'b0;
        pixel = '0;
        for (int i = 0; i < 2; i++) begin
            tick_cycle();
            check_color(color, COLOR_NONE, pixel);
        end
    endtask

    task automatic pulse_frames(input int n);
        for (int i = 0; i < n; i++) begin
            tick_cycle();
            frame_tick = 1'b1;
            tick_cycle();
            frame_tick = 1'b0;
            repeat (FRAME_GAP - 2) tick_cycle();
        end
    endtask

    task automatic scan_stimulus;
        int               fd;
        int               code;
        int               a1;
        logic [7:0]       op;
        logic [8*128-1:0] rest;
        fd = $fopen("bench/river_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file bench/river_stimulus.txt");
        end
        code = $fscanf(fd, " %c", op);
        while (code == 1) begin
            if (op == "F") begin
                code = $fscanf(fd, "%d", a1);
                frame_pulses += a1;
                cmd_lines++;
            end else begin
                code = $fgets(rest, fd);
                if (op != "#") begin
                    cmd_lines++;
                end
                if (op == "R") begin
                    reset_cmds++;
                end
            end
            code = $fscanf(fd, " %c", op);
        end
        $fclose(fd);
    endtask

    task automatic run_stimulus;
        int               fd;
        int               code;
        int               a1;
        int               a2;
        int               a3;
        int unsigned      gap;
        logic [7:0]       op;
        logic [8*128-1:0] rest;
        fd = $fopen("bench/river_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file bench/river_stimulus.txt");
        end
        code = $fscanf(fd, " %c", op);
        while (code == 1) begin
            if (op == "#") begin
                code = $fgets(rest, fd);
            end else if (op == "P") begin
                // one probe per cycle
                code = $fscanf(fd, "%d %d %h", a1, a2, a3);
                tick_cycle();
                pixel.col = a1[9:0];
                pixel.row = a2[9:0];
                probe_q.push_back(pixel);
                exp_q.push_back(a3[5:0]);
                due_q.push_back(cycle_count + 2);
            end else begin
                drain_pipeline();
                gap = $urandom % 4;
                repeat (gap) tick_cycle();
                case (op)
                    "R": do_reset();
                    "L": begin
                        code = $fscanf(fd, "%d", a1);
                        tick_cycle();
                        level = a1[1:0];
                    end
                    "F": begin
                        code = $fscanf(fd, "%d", a1);
                        pulse_frames(a1);
                    end
                    default: abort_run("unknown command in the stimulus file");
                endcase
            end
            code = $fscanf(fd, " %c", op);
        end
        $fclose(fd);
    endtask

    initial begin
        int unsigned seed_init;
        reset          = 1'b1;
        frame_tick     = 1'b0;
        level          = '0;
        pixel          = '0;
        cycle_count    = 0;
        error_count    = 0;
        cmd_lines      = 0;
        frame_pulses   = 0;
        reset_cmds     = 0;
        timeout_ready  = 1'b0;
        seed_init      = $urandom(32'h4faf_f92c);
        scan_stimulus();
        timeout_cycles = 2 * (cmd_lines * 6 + frame_pulses * FRAME_GAP
                              + reset_cmds * (RESET_CYCLES + 2)) + 100;
        timeout_ready  = 1'b1;
        run_stimulus();
        drain_pipeline();
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        wait (timeout_ready);
        #(timeout_cycles * CLK_PERIOD);
        abort_run($sformatf("watchdog expired, the run hung after %0d cycles", timeout_cycles));
    end

endmodule

`default_nettype wire

/* bench/river_stimulus.txt */
# R reset | L level | F frame count | P col row expected_color
# colors in hex: 00 none, 22 body, 11 grain, 10 knot, 33 cap
R
P 96 32 33
P 191 40 33
P 100 33 22
P 100 40 11
P 119 36 10
P 200 40 00
P 130 65 22
P 100 70 00
P 150 20 00
P 90 100 00
P 544 180 00
F 10
P 106 32 33
P 100 64 33
P 163 80 33
P 110 140 33
P 109 140 00
L 2
F 10
P 136 50 33
P 231 50 33
P 135 50 00
P 103 64 33
P 104 64 00
P 532 130 33
P 115 130 33
P 107 132 10
P 127 170 33
P 128 170 00
L 3
F 25
P 227 170 33
P 228 170 00
R
P 96 32 33

/* verilog.f */
hdl/screen_pkg.sv
hdl/river_pkg.sv
hdl/log_motion.sv
hdl/log_sprite_rom.sv
hdl/log_pixel_gen.sv
hdl/river_top.sv
bench/tb_clock.sv
bench/river_tb.sv
